//--- Bender.yml
package:
  name: jtag_debug_port

sources:
  - files:
      - jtag_pkg.sv
      - jtag_scan_if.sv
      - jtag_dr_if.sv
      - jtag_pin_sampler.sv
      - jtag_tap.sv
      - jtag_packet_bridge.sv
      - jtag_status_regs.sv
      - jtag_top.sv
  - target: test
    files:
      - jtag_properties.sv
      - tb_jtag_top.sv

//--- all.f
jtag_pkg.sv
jtag_scan_if.sv
jtag_dr_if.sv
jtag_pin_sampler.sv
jtag_tap.sv
jtag_packet_bridge.sv
jtag_status_regs.sv
jtag_top.sv
jtag_properties.sv
tb_jtag_top.sv

//--- jtag_dr_if.sv
//**************************************************
// data register traffic between the tap and the
// packet bridge / status register blocks
//**************************************************
`timescale 1ns/1ns

interface jtag_dr_if import jtag_pkg::*; ();

    logic        capture;      // capture_dr, one clk pulse
    logic        shift;        // shift_dr, one clk pulse
    logic        update;       // update_dr, one clk pulse
    jtag_instr_t instr;        // current ir
    logic        tdi;
    logic        data_tdo;     // lsb of DATA register
    logic        status_tdo;   // lsb of STATUS register

    modport tap (
        output capture, shift, update, instr, tdi,
        input  data_tdo, status_tdo
    );

    modport bridge (
        input  capture, shift, update, instr, tdi,
        output data_tdo
    );

    modport regs (
        input  capture, shift, update, instr, tdi,
        output status_tdo
    );

endinterface

//--- jtag_packet_bridge.sv
//**************************************************
// jtag packet bridge
// DATA register, one-entry tx buffer, rx output
//**************************************************
`timescale 1ns/1ns

module jtag_packet_bridge import jtag_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    jtag_dr_if.bridge        dr,
    input  logic [pkt_w-1:0] tx_data,
    input  logic             tx_valid,
    output logic             tx_ready,
    output logic [pkt_w-1:0] rx_data,
    output logic             rx_valid,
    input  logic             rx_ready,
    output logic             rx_drop
);

    logic [pkt_w-1:0]     tx_buf;
    logic                 tx_full;
    logic [data_dr_w-1:0] data_sr;    // {packet, flag}
    logic                 sel;        // DATA instruction active
    logic                 cap;
    logic                 upd_pkt;    // update with flag set
    logic                 rx_load;

    assign sel      = (dr.instr == instr_data);
    assign cap      = sel && dr.capture;
    assign upd_pkt  = sel && dr.update && data_sr[0];
    assign rx_drop  = upd_pkt && rx_valid && !rx_ready;   // rx still occupied
    assign rx_load  = upd_pkt && !rx_drop;
    assign tx_ready = !tx_full;

    assign dr.data_tdo = data_sr[0];

    always_ff @(posedge clk)
    begin
        if (rst)
            tx_full <= 1'b0;
        else if (tx_valid && tx_ready)
            tx_full <= 1'b1;
        else if (cap)
            tx_full <= 1'b0;       // packet moved into DATA register
    end

    always_ff @(posedge clk)
    begin
        if (tx_valid && tx_ready)
            tx_buf <= tx_data;
    end

    // shifts toward lsb, tdi enters at the top
    always_ff @(posedge clk)
    begin
        if (cap)
            data_sr <= tx_full ? {tx_buf, 1'b1} : '0;
        else if (sel && dr.shift)
            data_sr <= {dr.tdi, data_sr[data_dr_w-1:1]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rx_valid <= 1'b0;
        else if (rx_load)
            rx_valid <= 1'b1;
        else if (rx_ready)
            rx_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rx_load)
            rx_data <= data_sr[data_dr_w-1:1];   // held while rx_valid waits
    end

endmodule

//--- jtag_pin_sampler.sv
//**************************************************
// jtag pin sampler
// two-flop sync of the pins into clk, tck edge pulses
//**************************************************
`timescale 1ns/1ns

module jtag_pin_sampler (
    input  logic clk,
    input  logic rst,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    input  logic trst,
    jtag_scan_if.sampler scan
);

    logic [3:0] pin_meta;   // {trst, tdi, tms, tck}, first stage
    logic [3:0] pin_sync;   // second stage
    logic       tck_prev;   // last synced tck for edge detect

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pin_meta      <= '0;
            pin_sync      <= '0;
            tck_prev      <= 1'b0;
            scan.tck_rise <= 1'b0;
            scan.tck_fall <= 1'b0;
        end
        else
        begin
            pin_meta      <= {trst, tdi, tms, tck};
            pin_sync      <= pin_meta;
            tck_prev      <= pin_sync[0];
            scan.tck_rise <= pin_sync[0] & ~tck_prev;   // 3 clk after pin
            scan.tck_fall <= ~pin_sync[0] & tck_prev;
        end
    end

    assign scan.tms       = pin_sync[1];   // stable well before tck rise
    assign scan.tdi       = pin_sync[2];
    assign scan.trst_seen = pin_sync[3];

endmodule

//--- jtag_pkg.sv
//**************************************************
// jtag debug port package
// widths, device id, tap states and instruction codes
//**************************************************
package jtag_pkg;

    localparam int pkt_w       = 32;          // core packet payload
    localparam int ctrl_w      = 8;           // free-form ctrl inputs
    localparam int stat_w      = 8;           // free-form status outputs
    localparam int ir_w        = 4;           // instruction register
    localparam int idcode_w    = 32;
    localparam int data_dr_w   = pkt_w + 1;   // payload plus valid flag in bit 0
    localparam int status_dr_w = 16;

    localparam logic [idcode_w-1:0] idcode_value = 32'h2c5e_a0d3; // lsb must be 1
    localparam logic [ir_w-1:0]     ir_capture   = 4'b0001;        // loaded in capture_ir

    typedef enum logic [3:0] {
        test_logic_reset,
        run_test_idle,
        select_dr,
        capture_dr,
        shift_dr,
        exit1_dr,
        pause_dr,
        exit2_dr,
        update_dr,
        select_ir,
        capture_ir,
        shift_ir,
        exit1_ir,
        pause_ir,
        exit2_ir,
        update_ir
    } tap_state_t;

    // unlisted codes fall back to bypass
    typedef enum logic [ir_w-1:0] {
        instr_idcode = 4'd1,
        instr_data   = 4'd8,
        instr_status = 4'd9,
        instr_bypass = 4'd15
    } jtag_instr_t;

endpackage

//--- jtag_properties.sv
//**************************************************
// jtag debug port assertions
// tap reset, tdo idle level, tx and rx handshakes
//**************************************************
`timescale 1ns/1ns

module jtag_properties import jtag_pkg::*; (
    input logic             clk,
    input logic             rst,
    input tap_state_t       state,
    input logic             tck_fall,
    input logic             tdo,
    input logic             tx_valid,
    input logic             tx_ready,
    input logic             rx_valid,
    input logic             rx_ready,
    input logic [pkt_w-1:0] rx_data
);

    bit failed = 1'b0;   // sticky, seen by the testbench at the end

    reset_to_tlr: assert property (@(posedge clk) rst |=> state == test_logic_reset)
    else
    begin
        $error("tap not in test_logic_reset after reset");
        failed = 1'b1;
    end

    tdo_idle_low: assert property (@(posedge clk) disable iff (rst)
        tck_fall && !(state inside {shift_dr, shift_ir}) |=> !tdo)
    else
    begin
        $error("tdo not low outside the shift states");
        failed = 1'b1;
    end

    tx_accept: assert property (@(posedge clk) disable iff (rst)
        tx_valid && tx_ready |=> !tx_ready)
    else
    begin
        $error("tx_ready still high after a tx transfer");
        failed = 1'b1;
    end

    rx_hold: assert property (@(posedge clk) disable iff (rst)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data))
    else
    begin
        $error("rx packet not held while rx_ready is low");
        failed = 1'b1;
    end

endmodule

// tap state from the tap, handshakes at the bridge ports
bind jtag_top jtag_properties i_props (
    .clk      (clk),
    .rst      (rst),
    .state    (i_tap.state),
    .tck_fall (scan_bus.tck_fall),
    .tdo      (tdo),
    .tx_valid (tx_valid),
    .tx_ready (i_packet_bridge.tx_ready),
    .rx_valid (i_packet_bridge.rx_valid),
    .rx_ready (rx_ready),
    .rx_data  (i_packet_bridge.rx_data)
);

//--- jtag_scan_if.sv
//**************************************************
// jtag scan events, sampler to tap
//**************************************************
`timescale 1ns/1ns

interface jtag_scan_if ();

    logic tck_rise;    // one clk pulse per tck rising edge
    logic tck_fall;    // one clk pulse per tck falling edge
    logic tms;         // synchronized level
    logic tdi;         // synchronized level
    logic trst_seen;   // synchronized trst level

    modport sampler (
        output tck_rise,
        output tck_fall,
        output tms,
        output tdi,
        output trst_seen
    );

    modport tap (
        input tck_rise,
        input tck_fall,
        input tms,
        input tdi,
        input trst_seen
    );

endinterface

//--- jtag_status_regs.sv
//**************************************************
// jtag status registers
// STATUS scan register, status outputs, overflow flag
//**************************************************
`timescale 1ns/1ns

module jtag_status_regs import jtag_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    jtag_dr_if.regs           dr,
    input  logic [ctrl_w-1:0] ctrl,
    input  logic              tx_full,
    input  logic              rx_valid,
    input  logic              rx_drop,
    output logic [stat_w-1:0] status
);

    logic [status_dr_w-1:0] status_sr;
    logic                   overflow;    // sticky, set by dropped rx packet
    logic                   sel;
    logic                   upd;

    assign sel = (dr.instr == instr_status);
    assign upd = sel && dr.update;

    assign dr.status_tdo = status_sr[0];

    // capture layout {0, rx_valid, tx_full, overflow, ctrl}
    always_ff @(posedge clk)
    begin
        if (sel && dr.capture)
            status_sr <= {{(status_dr_w-ctrl_w-3){1'b0}}, rx_valid, tx_full, overflow, ctrl};
        else if (sel && dr.shift)
            status_sr <= {dr.tdi, status_sr[status_dr_w-1:1]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            status <= '0;
        else if (upd)
            status <= status_sr[stat_w-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            overflow <= 1'b0;
        else if (rx_drop)
            overflow <= 1'b1;                    // new drop wins over clear
        else if (upd && status_sr[ctrl_w])
            overflow <= 1'b0;
    end

endmodule

//--- jtag_tap.sv
//**************************************************
// jtag tap controller
// 16-state fsm, ir, idcode and bypass registers,
// dr strobes and the tdo mux
//**************************************************
`timescale 1ns/1ns

module jtag_tap import jtag_pkg::*; (
    input  logic clk,
    input  logic rst,
    jtag_scan_if.tap scan,
    jtag_dr_if.tap   dr,
    output logic tdo
);

    tap_state_t            state;
    tap_state_t            next_state;
    jtag_instr_t           ir;          // active instruction
    logic [ir_w-1:0]       ir_sr;       // ir shift stage
    logic [idcode_w-1:0]   idcode_sr;
    logic                  bypass_q;
    logic                  dr_bit;      // lsb of selected dr

    // standard 1149.1 transitions, sampled on tck rise
    always_comb
    begin
        case (state)
            test_logic_reset: next_state = scan.tms ? test_logic_reset : run_test_idle;
            run_test_idle:    next_state = scan.tms ? select_dr : run_test_idle;
            select_dr:        next_state = scan.tms ? select_ir : capture_dr;
            capture_dr:       next_state = scan.tms ? exit1_dr : shift_dr;
            shift_dr:         next_state = scan.tms ? exit1_dr : shift_dr;
            exit1_dr:         next_state = scan.tms ? update_dr : pause_dr;
            pause_dr:         next_state = scan.tms ? exit2_dr : pause_dr;
            exit2_dr:         next_state = scan.tms ? update_dr : shift_dr;
            update_dr:        next_state = scan.tms ? select_dr : run_test_idle;
            select_ir:        next_state = scan.tms ? test_logic_reset : capture_ir;
            capture_ir:       next_state = scan.tms ? exit1_ir : shift_ir;
            shift_ir:         next_state = scan.tms ? exit1_ir : shift_ir;
            exit1_ir:         next_state = scan.tms ? update_ir : pause_ir;
            pause_ir:         next_state = scan.tms ? exit2_ir : pause_ir;
            exit2_ir:         next_state = scan.tms ? update_ir : shift_ir;
            update_ir:        next_state = scan.tms ? select_dr : run_test_idle;
            default:          next_state = test_logic_reset;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || scan.trst_seen)
        begin
            state <= test_logic_reset;
            ir    <= instr_idcode;
        end
        else if (scan.tck_rise)
        begin
            state <= next_state;
            if (state == test_logic_reset)
                ir <= instr_idcode;             // five tms-high rises land here
            else if (state == update_ir)
                ir <= jtag_instr_t'(ir_sr);    // unknown codes act as bypass
        end
    end

    // ir, idcode and bypass shift stages, acted on in the state being left
    always_ff @(posedge clk)
    begin
        if (scan.tck_rise)
        begin
            case (state)
                capture_ir: ir_sr <= ir_capture;
                shift_ir:   ir_sr <= {scan.tdi, ir_sr[ir_w-1:1]};
                capture_dr:
                begin
                    idcode_sr <= idcode_value;
                    bypass_q  <= 1'b0;            // first bypass bit out is 0
                end
                shift_dr:
                begin
                    idcode_sr <= {scan.tdi, idcode_sr[idcode_w-1:1]};
                    bypass_q  <= scan.tdi;
                end
                default: ;
            endcase
        end
    end

    assign dr.capture = scan.tck_rise && (state == capture_dr);
    assign dr.shift   = scan.tck_rise && (state == shift_dr);
    assign dr.update  = scan.tck_rise && (state == update_dr);
    assign dr.instr   = ir;
    assign dr.tdi     = scan.tdi;

    always_comb
    begin
        case (ir)
            instr_idcode: dr_bit = idcode_sr[0];
            instr_data:   dr_bit = dr.data_tdo;
            instr_status: dr_bit = dr.status_tdo;
            instr_bypass: dr_bit = bypass_q;
            default:      dr_bit = bypass_q;
        endcase
    end

    // tdo changes after tck fall, zero outside the shift states
    always_ff @(posedge clk)
    begin
        if (rst)
            tdo <= 1'b0;
        else if (scan.tck_fall)
        begin
            if (state == shift_ir)
                tdo <= ir_sr[0];
            else if (state == shift_dr)
                tdo <= dr_bit;
            else
                tdo <= 1'b0;
        end
    end

endmodule

//--- jtag_top.sv
//**************************************************
// jtag debug port, device side
// pins to tap, packet stream and status vectors
//**************************************************
`timescale 1ns/1ns

module jtag_top import jtag_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              tck,
    input  logic              tms,
    input  logic              tdi,
    input  logic              trst,
    input  logic [ctrl_w-1:0] ctrl,
    input  logic [pkt_w-1:0]  tx_data,
    input  logic              tx_valid,
    input  logic              rx_ready,
    output logic              tdo,
    output logic [stat_w-1:0] status,
    output logic              tx_ready,
    output logic [pkt_w-1:0]  rx_data,
    output logic              rx_valid
);

    jtag_scan_if scan_bus ();
    jtag_dr_if   dr_bus ();

    logic tx_full;
    logic rx_drop;   // bridge to overflow flag

    assign tx_full = ~tx_ready;

    jtag_pin_sampler i_pin_sampler (
        .clk  (clk),
        .rst  (rst),
        .tck  (tck),
        .tms  (tms),
        .tdi  (tdi),
        .trst (trst),
        .scan (scan_bus.sampler)
    );

    jtag_tap i_tap (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_bus.tap),
        .dr   (dr_bus.tap),
        .tdo  (tdo)
    );

    jtag_packet_bridge i_packet_bridge (
        .clk      (clk),
        .rst      (rst),
        .dr       (dr_bus.bridge),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_drop  (rx_drop)
    );

    jtag_status_regs i_status_regs (
        .clk      (clk),
        .rst      (rst),
        .dr       (dr_bus.regs),
        .ctrl     (ctrl),
        .tx_full  (tx_full),
        .rx_valid (rx_valid),
        .rx_drop  (rx_drop),
        .status   (status)
    );

endmodule

//--- tb_jtag_top.sv
//**************************************************
// testbench for the jtag debug port
// table of tap scans and packet traffic, run in a loop
//**************************************************
`timescale 1ns/1ns

module tb_jtag_top import jtag_pkg::*;;

    typedef enum logic [1:0] {op_ir, op_dr, op_trst, op_tlr} op_kind_t;

    typedef struct packed {
        op_kind_t    kind;
        logic [7:0]  len;      // register length in bits
        logic [63:0] din;      // shifted in, lsb first
        logic [63:0] dout;     // expected out
        logic        tx_en;    // offer tx packet before the scan
        logic [31:0] tx;
        logic        rx_chk;   // rx_valid and rx_data checked after scan
        logic        rx_pop;   // then consumed with rx_ready
        logic [31:0] rx;
        logic        txr;      // tx_ready after the row
        logic [7:0]  st;       // status after the row
    } row_t;

    logic              clk;
    logic              rst;
    logic              tck;
    logic              tms;
    logic              tdi;
    logic              trst;
    logic [ctrl_w-1:0] ctrl;
    logic [pkt_w-1:0]  tx_data;
    logic              tx_valid;
    logic              rx_ready;
    logic              tdo;
    logic [stat_w-1:0] status;
    logic              tx_ready;
    logic [pkt_w-1:0]  rx_data;
    logic              rx_valid;

    row_t        rows[$];
    string       names[$];
    logic [31:0] seed = 32'hb6f75398;
    int          cycles = 0;
    int          limit = 0;

    jtag_top i_jtag_top (
        .clk      (clk),
        .rst      (rst),
        .tck      (tck),
        .tms      (tms),
        .tdi      (tdi),
        .trst     (trst),
        .ctrl     (ctrl),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .rx_ready (rx_ready),
        .tdo      (tdo),
        .status   (status),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout: run did not finish within %0d clk cycles", limit);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // STATUS capture word {0, rx_valid, tx_full, overflow, ctrl}
    function automatic logic [15:0] status_word(logic ovf, logic txf, logic rxv);
        return {5'b0, rxv, txf, ovf, ctrl};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s: expected %0h, actual %0h", what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input op_kind_t kind, input int len,
                           input logic [63:0] din, input logic [63:0] dout,
                           input logic tx_en, input logic [31:0] tx,
                           input logic rx_chk, input logic rx_pop, input logic [31:0] rx,
                           input logic txr, input logic [7:0] st);
        row_t r;
        r = '{kind, len[7:0], din, dout, tx_en, tx, rx_chk, rx_pop, rx, txr, st};
        rows.push_back(r);
        names.push_back(name);
    endtask

    // one tck period from a falling clk edge, tdo sampled just before the rise
    // returns after the rise has reached the tap
    task automatic clock_tck(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tck = 1'b0;
        tms = tms_v;
        tdi = tdi_v;
        repeat (4) @(negedge clk);
        tdo_v = tdo;
        tck = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    // idle to idle through capture, shift and update
    task automatic scan_reg(input logic is_ir, input int len, input logic [63:0] din,
                            output logic [63:0] dout);
        logic b;
        dout = '0;
        clock_tck(1'b1, 1'b0, b);              // select_dr
        if (is_ir)
            clock_tck(1'b1, 1'b0, b);          // select_ir
        clock_tck(1'b0, 1'b0, b);              // capture
        clock_tck(1'b0, 1'b0, b);              // shift
        for (int i = 0; i < len; i++)
        begin
            clock_tck(i == len - 1, din[i], b);
            dout[i] = b;
        end
        clock_tck(1'b1, 1'b0, b);              // update
        clock_tck(1'b0, 1'b0, b);              // back to idle
    endtask

    task automatic pulse_trst();
        logic b;
        @(negedge clk);
        trst = 1'b1;
        repeat (4) @(negedge clk);
        trst = 1'b0;
        repeat (4) @(negedge clk);
        clock_tck(1'b0, 1'b0, b);
    endtask

    task automatic tms_reset();
        logic b;
        repeat (5) clock_tck(1'b1, 1'b0, b);
        clock_tck(1'b0, 1'b0, b);
    endtask

    task automatic offer_tx(input string name, input logic [31:0] pkt);
        @(negedge clk);
        tx_data  = pkt;
        tx_valid = 1'b1;
        while (!tx_ready)
            @(negedge clk);
        @(negedge clk);
        tx_valid = 1'b0;
        check_value({name, " tx_ready after offer"}, 64'd0, tx_ready);
    endtask

    task automatic pop_rx(input string name);
        @(negedge clk);
        rx_ready = 1'b1;
        @(negedge clk);
        rx_ready = 1'b0;
        check_value({name, " rx_valid after pop"}, 64'd0, rx_valid);
    endtask

    task automatic build_table();
        logic [31:0] p1, p2, p3, p4, pat, s, c;
        p1  = next_rand();
        p2  = next_rand();
        p3  = next_rand();
        p4  = next_rand();
        pat = next_rand();
        s   = next_rand();
        c   = next_rand();
        ctrl = c[7:0];
        add_row("idcode_after_reset", op_dr, 32, 0, idcode_value, 0, 0, 0, 0, 0, 1, 0);
        add_row("ir_capture", op_ir, 4, instr_bypass, 4'b0001, 0, 0, 0, 0, 0, 1, 0);
        add_row("bypass_delay", op_dr, 16, pat[15:0], {pat[14:0], 1'b0},
                0, 0, 0, 0, 0, 1, 0);
        add_row("ir_data", op_ir, 4, instr_data, 4'b0001, 0, 0, 0, 0, 0, 1, 0);
        add_row("tx_to_data", op_dr, 33, 0, {p1, 1'b1}, 1, p1, 0, 0, 0, 1, 0);
        add_row("data_empty", op_dr, 33, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        add_row("rx_write", op_dr, 33, {p2, 1'b1}, 0, 0, 0, 1, 0, p2, 1, 0);
        // rx still held, second packet is dropped
        add_row("rx_drop", op_dr, 33, {p3, 1'b1}, 0, 0, 0, 1, 0, p2, 1, 0);
        add_row("ir_status", op_ir, 4, instr_status, 4'b0001, 0, 0, 0, 0, 0, 1, 0);
        // first packet still waiting on rx, popped after this scan
        add_row("status_overflow", op_dr, 16, {8'h00, s[7:0]}, status_word(1, 0, 1),
                0, 0, 1, 1, p2, 1, s[7:0]);
        add_row("status_clear", op_dr, 16, {8'h01, s[15:8]}, status_word(1, 0, 0),
                0, 0, 0, 0, 0, 1, s[15:8]);
        add_row("status_flags", op_dr, 16, {8'h00, s[15:8]}, status_word(0, 1, 0),
                1, p4, 0, 0, 0, 0, s[15:8]);
        add_row("ir_data_again", op_ir, 4, instr_data, 4'b0001, 0, 0, 0, 0, 0, 0, s[15:8]);
        add_row("data_after_status", op_dr, 33, 0, {p4, 1'b1}, 0, 0, 0, 0, 0, 1, s[15:8]);
        add_row("trst", op_trst, 0, 0, 0, 0, 0, 0, 0, 0, 1, s[15:8]);
        add_row("idcode_after_trst", op_dr, 32, 0, idcode_value, 0, 0, 0, 0, 0, 1, s[15:8]);
        add_row("ir_bypass_again", op_ir, 4, instr_bypass, 4'b0001, 0, 0, 0, 0, 0, 1, s[15:8]);
        add_row("tms_reset", op_tlr, 0, 0, 0, 0, 0, 0, 0, 0, 1, s[15:8]);
        add_row("idcode_after_tms", op_dr, 32, 0, idcode_value, 0, 0, 0, 0, 0, 1, s[15:8]);
    endtask

    initial
    begin
        row_t        r;
        logic [63:0] got;
        logic        b;
        rst      = 1'b1;
        tck      = 1'b0;
        tms      = 1'b0;
        tdi      = 1'b0;
        trst     = 1'b0;
        ctrl     = '0;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        build_table();
        limit = rows.size() * 500 + 400;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_value("reset tx_ready", 64'd1, tx_ready);
        check_value("reset rx_valid", 64'd0, rx_valid);
        check_value("reset status", 64'd0, status);
        check_value("reset tdo", 64'd0, tdo);
        clock_tck(1'b0, 1'b0, b);              // leave test_logic_reset
        for (int i = 0; i < rows.size(); i++)
        begin
            r = rows[i];
            if (r.tx_en)
                offer_tx(names[i], r.tx);
            case (r.kind)
                op_ir:   scan_reg(1'b1, r.len, r.din, got);
                op_dr:   scan_reg(1'b0, r.len, r.din, got);
                op_trst: pulse_trst();
                default: tms_reset();
            endcase
            if (r.kind == op_ir || r.kind == op_dr)
                check_value({names[i], " tdo bits"}, r.dout, got);
            if (r.rx_chk)
            begin
                check_value({names[i], " rx_valid"}, 64'd1, rx_valid);
                check_value({names[i], " rx_data"}, r.rx, rx_data);
            end
            if (r.rx_pop)
                pop_rx(names[i]);
            check_value({names[i], " tx_ready"}, r.txr, tx_ready);
            check_value({names[i], " status"}, r.st, status);
        end
        if (i_jtag_top.i_props.failed)
        begin
            $display("concurrent assertion failed during the run");
            $display("Simulation failed");
            $fatal(1, "assertion failure");
        end
        else
        begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
